// ==== common/mul_params.svh ====
////////////////////////////////////////
// Width macros for the multiply unit
// Word, half-word and accumulator sizes
////////////////////////////////////////

`ifndef MUL_PARAMS_SVH
`define MUL_PARAMS_SVH

// Operand and result word
`define MUL_XLEN  32

// One half-word slice of an operand
`define MUL_HALF  16

// Accumulator, one bit wider than a word to keep the sign
`define MUL_ACC_W 33

`endif

// ==== common/mul_op_pkg.sv ====
////////////////////////////////////////
// Instruction-level types of the multiply unit
// Function code, core operator, signedness pair
////////////////////////////////////////

package mul_op_pkg;

  // RV32M multiply function code, low two bits of funct3
  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHSU = 2'd2,
    MULHU  = 2'd3
  } mul_funct_e;

  // Operator seen by the multiplier core
  // MUL_M32 takes the single-cycle low-half path
  // MUL_H takes the four-step high-half path
  typedef enum logic {
    MUL_M32 = 1'b0,
    MUL_H   = 1'b1
  } mul_opcode_e;

  // Operand signedness
  // Bit 0 set when operand A is signed
  // Bit 1 set when operand B is signed
  typedef logic [1:0] short_signed_t;

endpackage

// ==== common/mul_dp_pkg.sv ====
////////////////////////////////////////
// Datapath types of the multiply unit
// Word, partial operand, accumulator, product, FSM state
////////////////////////////////////////

`include "mul_params.svh"

package mul_dp_pkg;

  // Operand or result word
  typedef logic [`MUL_XLEN-1:0] word_t;

  // Half-word operand with one extension bit on top
  typedef logic [`MUL_HALF:0] half_op_t;

  // Running sum of the high-half product
  typedef logic [`MUL_ACC_W-1:0] acc_t;

  // Output of the product adder
  typedef logic [`MUL_ACC_W:0] prod_t;

  // High-half FSM, one state per partial product
  typedef enum logic [1:0] {
    MUL_ALBL = 2'd0,
    MUL_ALBH = 2'd1,
    MUL_AHBL = 2'd2,
    MUL_AHBH = 2'd3
  } mult_state_e;

endpackage

// ==== mult/mul_core.sv ====
////////////////////////////////////////
// Multiplier core
// Single-cycle MUL, four-step MULH/MULHSU/MULHU
// 17-bit partial products into a 33-bit accumulator
////////////////////////////////////////

`timescale 1ns/10ps

`include "mul_params.svh"

module mul_core import mul_op_pkg::*, mul_dp_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,

  input  logic          valid_i,
  input  mul_opcode_e   operator_i,
  // Bit 0 for A, bit 1 for B
  input  short_signed_t short_signed_i,

  input  word_t         op_a_i,
  input  word_t         op_b_i,

  output word_t         result_o,

  output logic          ready_o,
  output logic          valid_o,
  input  logic          ready_i
);

  // Multiplier inputs after the MUL/MULH select
  word_t       op_a;
  word_t       op_b;
  prod_t       int_result;

  // Shift the sum down by one half word
  logic        mulh_shift;

  // High-half FSM
  mult_state_e mulh_state;
  mult_state_e mulh_state_next;

  // Partial operands
  half_op_t    mulh_al;
  half_op_t    mulh_bl;
  half_op_t    mulh_ah;
  half_op_t    mulh_bh;

  // Pair chosen for this step
  half_op_t    mulh_a;
  half_op_t    mulh_b;

  // Accumulator and its next value
  acc_t        mulh_acc;
  acc_t        mulh_acc_next;
  acc_t        mulh_acc_res;

  // Adder output, raw and shifted
  prod_t       result;
  prod_t       result_shifted;

  ////////////////////////////////////////
  // Partial operands
  ////////////////////////////////////////

  // Low halves are always unsigned
  assign mulh_al = {1'b0, op_a_i[`MUL_HALF-1:0]};
  assign mulh_bl = {1'b0, op_b_i[`MUL_HALF-1:0]};

  // Top bit of a high half carries the sign only for a signed operand
  assign mulh_ah = {short_signed_i[0] && op_a_i[`MUL_XLEN-1],
                    op_a_i[`MUL_XLEN-1:`MUL_HALF]};
  assign mulh_bh = {short_signed_i[1] && op_b_i[`MUL_XLEN-1],
                    op_b_i[`MUL_XLEN-1:`MUL_HALF]};

  ////////////////////////////////////////
  // High-half FSM
  ////////////////////////////////////////

  always_comb begin
    mulh_shift      = 1'b0;
    mulh_a          = mulh_al;
    mulh_b          = mulh_bl;
    mulh_state_next = mulh_state;
    ready_o         = 1'b0;
    valid_o         = 1'b0;
    // Idle or killed, accumulator starts from zero
    mulh_acc_next   = '0;

    case (mulh_state)
      MUL_ALBL: begin
        ready_o = 1'b1;
        if (valid_i) begin
          if (operator_i == MUL_H) begin
            // AL x BL, keep only the carry above bit 15
            mulh_shift      = 1'b1;
            ready_o         = 1'b0;
            mulh_acc_next   = mulh_acc_res;
            mulh_state_next = MUL_ALBH;
          end else begin
            // MUL, result straight from the adder
            valid_o = 1'b1;
          end
        end
      end

      MUL_ALBH: begin
        if (!valid_i) begin
          mulh_state_next = MUL_ALBL;
          ready_o         = 1'b1;
        end else begin
          // AL x BH lands at the same weight
          mulh_b          = mulh_bh;
          mulh_acc_next   = mulh_acc_res;
          mulh_state_next = MUL_AHBL;
        end
      end

      MUL_AHBL: begin
        if (!valid_i) begin
          mulh_state_next = MUL_ALBL;
          ready_o         = 1'b1;
        end else begin
          // AH x BL, then drop another half word
          mulh_shift      = 1'b1;
          mulh_a          = mulh_ah;
          mulh_acc_next   = mulh_acc_res;
          mulh_state_next = MUL_AHBH;
        end
      end

      MUL_AHBH: begin
        if (!valid_i) begin
          mulh_state_next = MUL_ALBL;
          ready_o         = 1'b1;
        end else begin
          // Final step, high word on result_o
          mulh_a        = mulh_ah;
          mulh_b        = mulh_bh;
          valid_o       = 1'b1;
          mulh_acc_next = mulh_acc;
          if (ready_i) begin
            // Taken downstream
            ready_o         = 1'b1;
            mulh_state_next = MUL_ALBL;
            mulh_acc_next   = '0;
          end
        end
      end

      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mulh_acc   <= '0;
      mulh_state <= MUL_ALBL;
    end else begin
      mulh_acc   <= mulh_acc_next;
      mulh_state <= mulh_state_next;
    end
  end

  // Arithmetic shift keeps the sign of a partial sum
  assign result_shifted = $signed(result) >>> `MUL_HALF;
  assign mulh_acc_res   = mulh_shift ? result_shifted[`MUL_ACC_W-1:0]
                                     : result[`MUL_ACC_W-1:0];

  ////////////////////////////////////////
  // Multiplier and product adder
  ////////////////////////////////////////

  // Full words for MUL, sign-extended 17-bit slices otherwise
  assign op_a = (operator_i == MUL_M32) ? op_a_i :
                {{`MUL_HALF{mulh_a[`MUL_HALF]}}, mulh_a[`MUL_HALF-1:0]};
  assign op_b = (operator_i == MUL_M32) ? op_b_i :
                {{`MUL_HALF{mulh_b[`MUL_HALF]}}, mulh_b[`MUL_HALF-1:0]};

  assign int_result = $signed(op_a) * $signed(op_b);

  // Accumulator stays zero on MUL
  assign result   = $signed(int_result) + $signed(mulh_acc);
  assign result_o = result[`MUL_XLEN-1:0];

  // A dropped request always sends the FSM back to idle
  a_idle_on_drop: assert property (@(posedge clk) disable iff (!rst_n)
    !valid_i |=> mulh_state == MUL_ALBL)
    else $error("mul_core: FSM not idle after valid_i fell");

  // No result without a request behind it
  a_no_orphan_valid: assert property (@(posedge clk) disable iff (!rst_n)
    !(valid_o && !valid_i))
    else $error("mul_core: valid_o without valid_i");

endmodule

// ==== verilog/mul_issue.sv ====
////////////////////////////////////////
// Request side of the multiply unit
// Latches one request, decodes it, holds it for the core
////////////////////////////////////////

`timescale 1ns/10ps

module mul_issue import mul_op_pkg::*, mul_dp_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          req_i,
  input  mul_funct_e    funct_i,
  input  word_t         op_a_i,
  input  word_t         op_b_i,
  input  logic          kill_i,
  input  logic          core_valid_i,
  input  logic          buf_ready_i,
  output logic          busy_o,
  output logic          valid_o,
  output mul_opcode_e   operator_o,
  output short_signed_t short_signed_o,
  output word_t         op_a_o,
  output word_t         op_b_o
);

  mul_opcode_e   dec_operator;
  short_signed_t dec_signed;
  logic          accept;
  logic          transfer;
  logic          valid_q;

  // Function code to core operator and signedness
  always_comb begin
    dec_operator = MUL_H;
    dec_signed   = 2'b00;
    case (funct_i)
      MUL:    dec_operator = MUL_M32;
      MULH:   dec_signed   = 2'b11;
      MULHSU: dec_signed   = 2'b01;
      MULHU:  dec_signed   = 2'b00;
      default: ;
    endcase
  end

  // New request only while idle
  assign accept   = req_i && !valid_q;
  // Result leaves the core into the buffer
  assign transfer = valid_q && core_valid_i && buf_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (kill_i || transfer) begin
      // Abandoned or done, core falls back to idle
      valid_q <= 1'b0;
    end
  end

  // Request payload, stays put while valid_q is high
  always_ff @(posedge clk) begin
    if (accept) begin
      operator_o     <= dec_operator;
      short_signed_o <= dec_signed;
      op_a_o         <= op_a_i;
      op_b_o         <= op_b_i;
    end
  end

  assign valid_o = valid_q;
  assign busy_o  = valid_q;

  // Upstream waits for busy_o to fall before the next strobe
  a_no_req_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |-> !busy_o)
    else $error("mul_issue: request strobe while busy");

endmodule

// ==== verilog/mul_result_buf.sv ====
////////////////////////////////////////
// Result side of the multiply unit
// One-entry register with valid/ready flow control
////////////////////////////////////////

`timescale 1ns/10ps

module mul_result_buf import mul_dp_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,

  // From the core
  input  logic  in_valid_i,
  input  word_t in_data_i,
  output logic  in_ready_o,

  // To the consumer
  output logic  result_valid_o,
  input  logic  result_ready_i,
  output word_t result_o
);

  logic  full_q;
  word_t data_q;
  logic  load;

  // Room when empty or when the held word leaves now
  assign in_ready_o = !full_q || result_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (result_ready_i) begin
      // Drained with nothing behind it
      full_q <= 1'b0;
    end
  end

  // Held word
  always_ff @(posedge clk) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign result_valid_o = full_q;
  assign result_o       = data_q;

  // A stalled word must survive until the consumer takes it
  a_hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    full_q && !result_ready_i |=> $stable(data_q))
    else $error("mul_result_buf: held word overwritten");

endmodule

// ==== verilog/mul_unit_top.sv ====
////////////////////////////////////////
// Multiply unit top level
// Request side, multiplier core, result register
////////////////////////////////////////

`timescale 1ns/10ps

module mul_unit_top import mul_op_pkg::*, mul_dp_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       req_i,
  input  mul_funct_e funct_i,
  input  word_t      op_a_i,
  input  word_t      op_b_i,
  input  logic       kill_i,
  output logic       busy_o,
  output logic       result_valid_o,
  input  logic       result_ready_i,
  output word_t      result_o
);

  // Request held for the core
  logic          core_valid;
  mul_opcode_e   core_operator;
  short_signed_t core_short_signed;
  word_t         core_op_a;
  word_t         core_op_b;

  // Core result and buffer flow control
  logic          core_valid_out;
  word_t         core_result;
  logic          buf_ready;

  mul_issue mul_issue_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .funct_i        (funct_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .kill_i         (kill_i),
    .core_valid_i   (core_valid_out),
    .buf_ready_i    (buf_ready),
    .busy_o         (busy_o),
    .valid_o        (core_valid),
    .operator_o     (core_operator),
    .short_signed_o (core_short_signed),
    .op_a_o         (core_op_a),
    .op_b_o         (core_op_b)
  );

  // Completion is seen by the request side from the transfer
  mul_core mul_core_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (core_valid),
    .operator_i     (core_operator),
    .short_signed_i (core_short_signed),
    .op_a_i         (core_op_a),
    .op_b_i         (core_op_b),
    .result_o       (core_result),
    .ready_o        (),
    .valid_o        (core_valid_out),
    .ready_i        (buf_ready)
  );

  mul_result_buf mul_result_buf_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid_i     (core_valid_out),
    .in_data_i      (core_result),
    .in_ready_o     (buf_ready),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o)
  );

endmodule

// ==== verification/tb_mul_unit.sv ====
////////////////////////////////////////
// Testbench for the multiply unit
// Clock, reset, stimulus, reference model
// Result compare, watchdog and report
////////////////////////////////////////

`timescale 1ns/10ps

module tb_mul_unit import mul_op_pkg::*, mul_dp_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int RST_CYCLES = 5;
  localparam int N_MUL      = 16;
  localparam int N_CORNER   = 75;
  localparam int N_HI_RAND  = 8;
  localparam int N_MIX      = 40;
  localparam int N_KILL     = 8;
  // Every kill round issues the killed request and one follow-up
  localparam int TOTAL_OPS  = N_MUL + N_CORNER + 3 * N_HI_RAND + N_MIX + 2 * N_KILL;
  localparam int WATCHDOG_NS = (TOTAL_OPS * 40 + RST_CYCLES) * CLK_PERIOD;

  logic       clk;
  logic       rst_n;
  logic       req_i;
  mul_funct_e funct_i;
  word_t      op_a_i;
  word_t      op_b_i;
  logic       kill_i;
  logic       busy_o;
  logic       result_valid_o;
  logic       result_ready_i;
  word_t      result_o;

  // Expected words, expected latency (0 means unchecked), request cycle
  word_t      exp_q[$];
  int         lat_q[$];
  int         cyc_q[$];

  int         cyc;
  int         err_cnt;
  int         n_checks;
  int         n_tests;
  int         err_start;
  bit         rand_ready;
  word_t      exp_w;
  int         exp_lat;
  int         req_cyc;

  mul_unit_top mul_unit_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (req_i),
    .funct_i        (funct_i),
    .op_a_i         (op_a_i),
    .op_b_i         (op_b_i),
    .kill_i         (kill_i),
    .busy_o         (busy_o),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_o       (result_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Consumer ready, random while back-pressure is on
  always @(posedge clk) begin
    #1;
    if (rand_ready) begin
      result_ready_i = $urandom_range(0, 1);
    end else begin
      result_ready_i = 1'b1;
    end
  end

  ////////////////////////////////////////
  // Reference model and helpers
  ////////////////////////////////////////

  // 64-bit product of the extended operands
  function automatic word_t ref_mul(input mul_funct_e f, input word_t a, input word_t b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] prod;
    ext_a = {{32{(f == MULH || f == MULHSU) && a[31]}}, a};
    ext_b = {{32{(f == MULH) && b[31]}}, b};
    prod  = ext_a * ext_b;
    if (f == MUL) begin
      return prod[31:0];
    end
    return prod[63:32];
  endfunction

  function automatic word_t corner_val(input int idx);
    case (idx)
      0:       return 32'h0000_0000;
      1:       return 32'h0000_0001;
      2:       return 32'hffff_ffff;
      3:       return 32'h8000_0000;
      default: return 32'h7fff_ffff;
    endcase
  endfunction

  // Entered and left 1 ns after a rising edge
  task automatic issue_op(input mul_funct_e f, input word_t a, input word_t b,
                          input int lat, input bit keep);
    while (busy_o) begin
      @(posedge clk);
      #1;
    end
    req_i   = 1'b1;
    funct_i = f;
    op_a_i  = a;
    op_b_i  = b;
    if (keep) begin
      exp_q.push_back(ref_mul(f, a, b));
      lat_q.push_back(lat);
      cyc_q.push_back(cyc);
    end
    @(posedge clk);
    #1;
    req_i = 1'b0;
  endtask

  task automatic drain_results(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected results never arrived", exp_q.size());
      err_cnt++;
      exp_q.delete();
      lat_q.delete();
      cyc_q.delete();
    end
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    $display("test %0d %s: %0d errors", n_tests, name, err_cnt - err_start);
    err_start = err_cnt;
  endtask

  ////////////////////////////////////////
  // Result compare
  ////////////////////////////////////////

  // Sampled on the falling edge, away from register updates
  always @(negedge clk) begin
    if (rst_n && result_valid_o && result_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("unexpected result %h at %0t with no request pending", result_o, $time);
        err_cnt++;
      end else begin
        exp_w   = exp_q.pop_front();
        exp_lat = lat_q.pop_front();
        req_cyc = cyc_q.pop_front();
        n_checks++;
        assert (result_o === exp_w) else begin
          $display("ERR %0t: result expected %h got %h", $time, exp_w, result_o);
          err_cnt++;
        end
        if (exp_lat != 0) begin
          assert (cyc - req_cyc == exp_lat) else begin
            $display("ERR %0t: latency expected %0d got %0d", $time, exp_lat, cyc - req_cyc);
            err_cnt++;
          end
        end
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with the run unfinished", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    int    d;
    word_t a;
    word_t b;
    rst_n          = 1'b0;
    req_i          = 1'b0;
    funct_i        = MUL;
    op_a_i         = '0;
    op_b_i         = '0;
    kill_i         = 1'b0;
    result_ready_i = 1'b1;
    rand_ready     = 1'b0;
    cyc            = 0;
    err_cnt        = 0;
    n_checks       = 0;
    n_tests        = 0;
    err_start      = 0;
    d = $urandom(32'hf859b011);

    repeat (RST_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle after reset
    repeat (4) begin
      @(posedge clk);
      #1;
      assert (!busy_o && !result_valid_o) else begin
        $display("ERR %0t: busy %b valid %b after reset", $time, busy_o, result_valid_o);
        err_cnt++;
      end
    end
    finish_test("reset idle");

    for (int i = 0; i < N_MUL; i++) begin
      issue_op(MUL, $urandom, $urandom, 2, 1'b1);
    end
    drain_results(20);
    finish_test("random mul");

    // Every corner pair under each high-half code, then random ones
    for (int c = 1; c < 4; c++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          issue_op(mul_funct_e'(c), corner_val(i), corner_val(j), 5, 1'b1);
        end
      end
      for (int i = 0; i < N_HI_RAND; i++) begin
        issue_op(mul_funct_e'(c), $urandom, $urandom, 5, 1'b1);
      end
    end
    drain_results(20);
    finish_test("high half");

    rand_ready = 1'b1;
    for (int i = 0; i < N_MIX; i++) begin
      issue_op(mul_funct_e'($urandom_range(0, 3)), $urandom, $urandom, 0, 1'b1);
    end
    rand_ready = 1'b0;
    drain_results(100);
    finish_test("back-pressure mix");

    for (int i = 0; i < N_KILL; i++) begin
      // Kill lands in ALBL, ALBH or AHBL, before the result can leave
      d = $urandom_range(0, 2);
      a = $urandom | 32'h8000_0001;
      b = $urandom | 32'h8000_0001;
      issue_op(mul_funct_e'($urandom_range(1, 3)), a, b, 0, 1'b0);
      repeat (d) begin
        @(posedge clk);
        #1;
      end
      kill_i = 1'b1;
      @(posedge clk);
      #1;
      kill_i = 1'b0;
      assert (!busy_o) else begin
        $display("ERR %0t: busy still high after kill", $time);
        err_cnt++;
      end
      repeat (6) begin
        @(posedge clk);
        #1;
        assert (!result_valid_o) else begin
          $display("ERR %0t: result %h from a killed request", $time, result_o);
          err_cnt++;
        end
      end
      issue_op(mul_funct_e'($urandom_range(1, 3)), $urandom, $urandom, 5, 1'b1);
      drain_results(20);
    end
    finish_test("kill");

    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+common
common/mul_op_pkg.sv
common/mul_dp_pkg.sv
mult/mul_core.sv
verilog/mul_issue.sv
verilog/mul_result_buf.sv
verilog/mul_unit_top.sv
verification/tb_mul_unit.sv
